//--- all.f
tile_pkg.sv
tc_clk_gating.sv
z_buffer_scm.sv
write_arbiter.sv
line_port.sv
tile_transposer_top.sv
tile_transposer_properties.sv
tb_tile_transposer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_tile_transposer
FILELIST  := all.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

//--- tb_tile_transposer.sv
// Testbench for the tile transposer with ROWS = COLS = 4.
// Each port has at most one write and one read outstanding at a time.
module tb_tile_transposer;
  import tile_pkg::*;

  localparam int Rows = 4;
  localparam int Cols = 4;
  // The tests take under 1000 cycles with the longest back-pressure stretches.
  localparam int MaxCycles = 4000;

  logic                 clk_i = 1'b0;
  logic                 rst_ni = 1'b0;
  logic [AddrWidth-1:0] awaddr [2];
  logic [DataWidth-1:0] wdata [2];
  logic [AddrWidth-1:0] araddr [2];
  logic [DataWidth-1:0] rdata [2];
  logic [1:0]           bresp [2];
  logic [1:0]           rresp [2];
  logic [1:0]           awvalid, wvalid, bready, arvalid, rready;
  logic [1:0]           awready, wready, bvalid, arready, rvalid;

  // Reference state. Index 0 is the row port and 1 the column port.
  logic [DataWidth-1:0] model [Rows][Cols];
  logic [DataWidth-1:0] stage [2][4];
  logic [1:0]           exp_bresp [2];
  logic [1:0]           exp_rresp [2];
  logic [DataWidth-1:0] exp_rdata [2];
  logic [DataWidth-1:0] exp_ralt [2];
  logic [1:0]           b_hold, r_hold;
  logic [1:0]           b_last [2];
  logic [DataWidth-1:0] r_last [2];
  int                   checks = 0;
  int                   errors = 0;
  int                   cycles = 0;

  always #5 clk_i = ~clk_i;

  tile_transposer_top #(.ROWS(Rows), .COLS(Cols)) i_dut (
    .clk_i, .rst_ni,
    .row_awaddr_i (awaddr[0]), .row_awvalid_i (awvalid[0]), .row_awready_o (awready[0]),
    .row_wdata_i  (wdata[0]),  .row_wvalid_i  (wvalid[0]),  .row_wready_o  (wready[0]),
    .row_bresp_o  (bresp[0]),  .row_bvalid_o  (bvalid[0]),  .row_bready_i  (bready[0]),
    .row_araddr_i (araddr[0]), .row_arvalid_i (arvalid[0]), .row_arready_o (arready[0]),
    .row_rdata_o  (rdata[0]),  .row_rresp_o   (rresp[0]),   .row_rvalid_o  (rvalid[0]),
    .row_rready_i (rready[0]),
    .col_awaddr_i (awaddr[1]), .col_awvalid_i (awvalid[1]), .col_awready_o (awready[1]),
    .col_wdata_i  (wdata[1]),  .col_wvalid_i  (wvalid[1]),  .col_wready_o  (wready[1]),
    .col_bresp_o  (bresp[1]),  .col_bvalid_o  (bvalid[1]),  .col_bready_i  (bready[1]),
    .col_araddr_i (araddr[1]), .col_arvalid_i (arvalid[1]), .col_arready_o (arready[1]),
    .col_rdata_o  (rdata[1]),  .col_rresp_o   (rresp[1]),   .col_rvalid_o  (rvalid[1]),
    .col_rready_i (rready[1])
  );

  function automatic logic [AddrWidth-1:0] addr_of(input int line, input int word);
    return AddrWidth'((line << 4) | (word << 2));
  endfunction

  // Write side of the model. A line reaches the matrix on its last word.
  function automatic logic [1:0] ref_write(input int p, input logic [AddrWidth-1:0] addr,
                                           input logic [DataWidth-1:0] data);
    int word;
    int line;
    word = int'(addr[3:2]);
    line = int'(addr[AddrWidth-1:4]);
    if (line >= ((p == 0) ? Rows : Cols)) return RespSlvErr;
    stage[p][word] = data;
    if (word == ((p == 0) ? Cols : Rows) - 1) begin
      for (int i = 0; i < 4; i++) begin
        if (p == 0) model[line][i] = stage[0][i];
        else model[i][line] = stage[1][i];
      end
    end
    return RespOkay;
  endfunction

  // Read side of the model. The column port sees the matrix transposed.
  function automatic logic [DataWidth-1:0] ref_read(input int p,
                                                    input logic [AddrWidth-1:0] addr,
                                                    output logic [1:0] resp);
    int word;
    int line;
    word = int'(addr[3:2]);
    line = int'(addr[AddrWidth-1:4]);
    resp = RespOkay;
    if (line >= ((p == 0) ? Rows : Cols)) begin
      resp = RespSlvErr;
      return '0;
    end
    return (p == 0) ? model[line][word] : model[word][line];
  endfunction

  task automatic write_word(input int p, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data, input int bdelay);
    @(negedge clk_i);
    exp_bresp[p] = ref_write(p, addr, data);
    awaddr[p]  = addr;
    wdata[p]   = data;
    awvalid[p] = 1'b1;
    wvalid[p]  = 1'b1;
    do @(posedge clk_i); while (!awready[p]);
    @(negedge clk_i);
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    repeat (bdelay) @(negedge clk_i);
    bready[p] = 1'b1;
    do @(posedge clk_i); while (!bvalid[p]);
    @(negedge clk_i);
    bready[p] = 1'b0;
  endtask

  // With two_ok set, either opt_a or opt_b is an accepted read value.
  task automatic read_word(input int p, input logic [AddrWidth-1:0] addr, input int rdelay,
                           input bit two_ok, input logic [DataWidth-1:0] opt_a,
                           input logic [DataWidth-1:0] opt_b);
    @(negedge clk_i);
    exp_rdata[p] = ref_read(p, addr, exp_rresp[p]);
    exp_ralt[p]  = exp_rdata[p];
    if (two_ok) begin
      exp_rdata[p] = opt_a;
      exp_ralt[p]  = opt_b;
    end
    araddr[p]  = addr;
    arvalid[p] = 1'b1;
    do @(posedge clk_i); while (!arready[p]);
    @(negedge clk_i);
    arvalid[p] = 1'b0;
    repeat (rdelay) @(negedge clk_i);
    rready[p] = 1'b1;
    do @(posedge clk_i); while (!rvalid[p]);
    @(negedge clk_i);
    rready[p] = 1'b0;
  endtask

  task automatic read_all(input int p, input int max_delay);
    for (int l = 0; l < 4; l++) begin
      for (int w = 0; w < 4; w++) begin
        read_word(p, addr_of(l, w), $urandom_range(max_delay, 0), 1'b0, '0, '0);
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("%s: done with %0d errors", name, errors - errs_before);
  endtask

  // Compares every B and R beat and checks that held responses stay stable.
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int p = 0; p < 2; p++) begin
        if (awready[p] !== wready[p]) begin
          errors++;
          $display("AW and W on port %0d were not accepted together", p);
        end
        if (b_hold[p] && (!bvalid[p] || bresp[p] !== b_last[p])) begin
          errors++;
          $display("B response on port %0d changed before bready", p);
        end
        if (r_hold[p] && (!rvalid[p] || rdata[p] !== r_last[p])) begin
          errors++;
          $display("R response on port %0d changed before rready", p);
        end
        if (bvalid[p] && bready[p]) begin
          checks++;
          if (bresp[p] !== exp_bresp[p]) begin
            errors++;
            $display("Fail port %0d bresp: expected %h, got %h", p, exp_bresp[p], bresp[p]);
          end
        end
        if (rvalid[p] && rready[p]) begin
          checks++;
          if (rresp[p] !== exp_rresp[p]) begin
            errors++;
            $display("Fail port %0d rresp: expected %h, got %h", p, exp_rresp[p], rresp[p]);
          end
          if (rdata[p] !== exp_rdata[p] && rdata[p] !== exp_ralt[p]) begin
            errors++;
            $display("Fail port %0d rdata: expected %h, got %h", p, exp_rdata[p], rdata[p]);
          end
        end
        b_hold[p] = bvalid[p] && !bready[p];
        r_hold[p] = rvalid[p] && !rready[p];
        b_last[p] = bresp[p];
        r_last[p] = rdata[p];
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int                   errs;
    logic [DataWidth-1:0] d_row2;
    logic [DataWidth-1:0] d_col1;
    void'($urandom(18308));
    for (int p = 0; p < 2; p++) begin
      awaddr[p] = '0;
      wdata[p]  = '0;
      araddr[p] = '0;
      for (int i = 0; i < 4; i++) stage[p][i] = '0;
    end
    for (int r = 0; r < Rows; r++) begin
      for (int c = 0; c < Cols; c++) model[r][c] = '0;
    end
    {awvalid, wvalid, bready, arvalid, rready, b_hold, r_hold} = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if ({awready, wready, arready, bvalid, rvalid} !== '0) begin
      errors++;
      $display("Handshake outputs are not low after reset");
    end

    errs = errors;
    read_all(0, 0);
    read_all(1, 0);
    end_test("reset contents", errs);

    errs = errors;
    for (int r = 0; r < Rows; r++) begin
      for (int c = 0; c < Cols; c++) write_word(0, addr_of(r, c), $urandom, 0);
    end
    read_all(1, 0);
    end_test("row write, column read", errs);

    errs = errors;
    for (int c = 0; c < Cols; c++) begin
      for (int r = 0; r < Rows; r++) write_word(1, addr_of(c, r), $urandom, 0);
    end
    read_all(0, 0);
    end_test("column write, row read", errs);

    // Row 1 and column 2 commit together and share word [1][2].
    errs = errors;
    d_row2 = $urandom;
    d_col1 = $urandom;
    for (int w = 0; w < 3; w++) begin
      write_word(0, addr_of(1, w), (w == 2) ? d_row2 : $urandom, 0);
      write_word(1, addr_of(2, w), (w == 1) ? d_col1 : $urandom, 0);
    end
    fork
      write_word(0, addr_of(1, 3), $urandom, 0);
      write_word(1, addr_of(2, 3), $urandom, 0);
    join
    for (int w = 0; w < 4; w++) begin
      read_word(0, addr_of(1, w), 0, w == 2, d_row2, d_col1);
      read_word(1, addr_of(2, w), 0, w == 1, d_row2, d_col1);
    end
    for (int w = 0; w < 4; w++) write_word(0, addr_of(1, w), $urandom, 0);
    end_test("simultaneous commits", errs);

    errs = errors;
    for (int w = 0; w < 4; w++) write_word(0, addr_of(2, w), $urandom, $urandom_range(5, 0));
    for (int w = 0; w < 4; w++) write_word(1, addr_of(3, w), $urandom, $urandom_range(5, 0));
    read_all(0, 5);
    read_all(1, 5);
    end_test("back-pressure", errs);

    errs = errors;
    write_word(0, addr_of(5, 3), $urandom, 0);
    write_word(1, addr_of(9, 1), $urandom, 2);
    read_word(0, addr_of(4, 0), 0, 1'b0, '0, '0);
    read_word(1, addr_of(200, 3), 1, 1'b0, '0, '0);
    read_all(0, 0);
    end_test("out of range", errs);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tile_transposer_properties.sv
// Handshake and arbitration assertions bound into line_port and write_arbiter.
// Unused inputs of a binding are tied low.
module tile_transposer_properties import tile_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 bvalid_i,
  input logic                 bready_i,
  input logic [1:0]           bresp_i,
  input logic                 rvalid_i,
  input logic                 rready_i,
  input logic [DataWidth-1:0] rdata_i,
  input logic [1:0]           rresp_i,
  input logic                 req_a_i,
  input logic                 gnt_a_i,
  input logic                 req_b_i,
  input logic                 gnt_b_i
);

  // A response holds with stable payload until it is taken.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("B response dropped or changed before bready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else $error("R response dropped or changed before rready");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(gnt_a_i && gnt_b_i))
    else $error("Both commit requests granted in one cycle");

  // A waiting request is granted on the next cycle at the latest.
  assert property (@(posedge clk_i) disable iff (!rst_ni) req_a_i && !gnt_a_i |=> gnt_a_i)
    else $error("Commit request not granted in time");

  assert property (@(posedge clk_i) disable iff (!rst_ni) req_b_i && !gnt_b_i |=> gnt_b_i)
    else $error("Commit request not granted in time");

endmodule

bind line_port tile_transposer_properties i_port_props (
  .clk_i, .rst_ni,
  .bvalid_i (bvalid_o), .bready_i, .bresp_i (bresp_o),
  .rvalid_i (rvalid_o), .rready_i, .rdata_i (rdata_o), .rresp_i (rresp_o),
  .req_a_i (commit_req_o), .gnt_a_i (commit_gnt_i), .req_b_i (1'b0), .gnt_b_i (1'b0)
);

bind write_arbiter tile_transposer_properties i_arb_props (
  .clk_i, .rst_ni,
  .bvalid_i (1'b0), .bready_i (1'b0), .bresp_i (2'b00),
  .rvalid_i (1'b0), .rready_i (1'b0), .rdata_i ('0), .rresp_i (2'b00),
  .req_a_i (row_req_i), .gnt_a_i (row_gnt_o), .req_b_i (col_req_i), .gnt_b_i (col_gnt_o)
);

//--- tile_transposer_top.sv
// Transposing tile buffer with a row AXI4-Lite port and a column AXI4-Lite port.
// Line commits are arbitrated; the two read paths run independently.
module tile_transposer_top import tile_pkg::*; #(
  parameter int unsigned ROWS = 4,
  parameter int unsigned COLS = 4,
  localparam int unsigned RowAw = (ROWS > 1) ? $clog2(ROWS) : 1,
  localparam int unsigned ColAw = (COLS > 1) ? $clog2(COLS) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] row_awaddr_i,
  input  logic                 row_awvalid_i,
  output logic                 row_awready_o,
  input  logic [DataWidth-1:0] row_wdata_i,
  input  logic                 row_wvalid_i,
  output logic                 row_wready_o,
  output logic [1:0]           row_bresp_o,
  output logic                 row_bvalid_o,
  input  logic                 row_bready_i,
  input  logic [AddrWidth-1:0] row_araddr_i,
  input  logic                 row_arvalid_i,
  output logic                 row_arready_o,
  output logic [DataWidth-1:0] row_rdata_o,
  output logic [1:0]           row_rresp_o,
  output logic                 row_rvalid_o,
  input  logic                 row_rready_i,
  input  logic [AddrWidth-1:0] col_awaddr_i,
  input  logic                 col_awvalid_i,
  output logic                 col_awready_o,
  input  logic [DataWidth-1:0] col_wdata_i,
  input  logic                 col_wvalid_i,
  output logic                 col_wready_o,
  output logic [1:0]           col_bresp_o,
  output logic                 col_bvalid_o,
  input  logic                 col_bready_i,
  input  logic [AddrWidth-1:0] col_araddr_i,
  input  logic                 col_arvalid_i,
  output logic                 col_arready_o,
  output logic [DataWidth-1:0] col_rdata_o,
  output logic [1:0]           col_rresp_o,
  output logic                 col_rvalid_o,
  input  logic                 col_rready_i
);

  logic                           row_commit_req;
  logic                           row_commit_gnt;
  logic [RowAw-1:0]               row_commit_line;
  logic [COLS-1:0][DataWidth-1:0] row_commit_data;
  logic                           row_rd_en;
  logic [RowAw-1:0]               row_rd_addr;
  logic [COLS-1:0][DataWidth-1:0] row_rd_line;
  logic                           col_commit_req;
  logic                           col_commit_gnt;
  logic [ColAw-1:0]               col_commit_line;
  logic [ROWS-1:0][DataWidth-1:0] col_commit_data;
  logic                           col_rd_en;
  logic [ColAw-1:0]               col_rd_addr;
  logic [ROWS-1:0][DataWidth-1:0] col_rd_line;
  logic                           row_write_en;
  logic                           col_write_en;
  logic [RowAw-1:0]               row_write_addr;
  logic [ColAw-1:0]               col_write_addr;
  logic [COLS-1:0][DataWidth-1:0] row_wdata;
  logic [ROWS-1:0][DataWidth-1:0] col_wdata;

  // A row is COLS words long, and there are ROWS of them.
  line_port #(
    .LINE_LEN  (COLS),
    .NUM_LINES (ROWS)
  ) i_row_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .awaddr_i      (row_awaddr_i),
    .awvalid_i     (row_awvalid_i),
    .awready_o     (row_awready_o),
    .wdata_i       (row_wdata_i),
    .wvalid_i      (row_wvalid_i),
    .wready_o      (row_wready_o),
    .bresp_o       (row_bresp_o),
    .bvalid_o      (row_bvalid_o),
    .bready_i      (row_bready_i),
    .araddr_i      (row_araddr_i),
    .arvalid_i     (row_arvalid_i),
    .arready_o     (row_arready_o),
    .rdata_o       (row_rdata_o),
    .rresp_o       (row_rresp_o),
    .rvalid_o      (row_rvalid_o),
    .rready_i      (row_rready_i),
    .commit_req_o  (row_commit_req),
    .commit_gnt_i  (row_commit_gnt),
    .commit_line_o (row_commit_line),
    .commit_data_o (row_commit_data),
    .rd_en_o       (row_rd_en),
    .rd_addr_o     (row_rd_addr),
    .rd_line_i     (row_rd_line)
  );

  line_port #(
    .LINE_LEN  (ROWS),
    .NUM_LINES (COLS)
  ) i_col_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .awaddr_i      (col_awaddr_i),
    .awvalid_i     (col_awvalid_i),
    .awready_o     (col_awready_o),
    .wdata_i       (col_wdata_i),
    .wvalid_i      (col_wvalid_i),
    .wready_o      (col_wready_o),
    .bresp_o       (col_bresp_o),
    .bvalid_o      (col_bvalid_o),
    .bready_i      (col_bready_i),
    .araddr_i      (col_araddr_i),
    .arvalid_i     (col_arvalid_i),
    .arready_o     (col_arready_o),
    .rdata_o       (col_rdata_o),
    .rresp_o       (col_rresp_o),
    .rvalid_o      (col_rvalid_o),
    .rready_i      (col_rready_i),
    .commit_req_o  (col_commit_req),
    .commit_gnt_i  (col_commit_gnt),
    .commit_line_o (col_commit_line),
    .commit_data_o (col_commit_data),
    .rd_en_o       (col_rd_en),
    .rd_addr_o     (col_rd_addr),
    .rd_line_i     (col_rd_line)
  );

  write_arbiter #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) i_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .row_req_i        (row_commit_req),
    .col_req_i        (col_commit_req),
    .row_gnt_o        (row_commit_gnt),
    .col_gnt_o        (col_commit_gnt),
    .row_line_i       (row_commit_line),
    .col_line_i       (col_commit_line),
    .row_data_i       (row_commit_data),
    .col_data_i       (col_commit_data),
    .row_write_en_o   (row_write_en),
    .col_write_en_o   (col_write_en),
    .row_write_addr_o (row_write_addr),
    .col_write_addr_o (col_write_addr),
    .row_wdata_o      (row_wdata),
    .col_wdata_o      (col_wdata)
  );

  z_buffer_scm #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) i_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .row_write_en_i   (row_write_en),
    .col_write_en_i   (col_write_en),
    .row_write_addr_i (row_write_addr),
    .col_write_addr_i (col_write_addr),
    .row_wdata_i      (row_wdata),
    .col_wdata_i      (col_wdata),
    .row_read_en_i    (row_rd_en),
    .col_read_en_i    (col_rd_en),
    .row_read_addr_i  (row_rd_addr),
    .col_read_addr_i  (col_rd_addr),
    .row_rdata_o      (row_rd_line),
    .col_rdata_o      (col_rd_line)
  );

endmodule

//--- line_port.sv
// AXI4-Lite slave that stages one line and commits it on its last word.
// No bursts; wstrb is absent and every write is a full word.
// The address must hold at least the line index bits above the word index.
module line_port import tile_pkg::*; #(
  parameter int unsigned LINE_LEN  = 4,
  parameter int unsigned NUM_LINES = 4,
  localparam int unsigned WordAw = (LINE_LEN > 1) ? $clog2(LINE_LEN) : 1,
  localparam int unsigned LineAw = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1,
  localparam int unsigned LineLsb = ByteOffset + WordAw
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [AddrWidth-1:0]               awaddr_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [DataWidth-1:0]               wdata_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,
  output logic [1:0]                         bresp_o,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  input  logic [AddrWidth-1:0]               araddr_i,
  input  logic                               arvalid_i,
  output logic                               arready_o,
  output logic [DataWidth-1:0]               rdata_o,
  output logic [1:0]                         rresp_o,
  output logic                               rvalid_o,
  input  logic                               rready_i,
  output logic                               commit_req_o,
  input  logic                               commit_gnt_i,
  output logic [LineAw-1:0]                  commit_line_o,
  output logic [LINE_LEN-1:0][DataWidth-1:0] commit_data_o,
  output logic                               rd_en_o,
  output logic [LineAw-1:0]                  rd_addr_o,
  input  logic [LINE_LEN-1:0][DataWidth-1:0] rd_line_i
);

  logic [WordAw-1:0]                  aw_word;
  logic [AddrWidth-LineLsb-1:0]       aw_line;
  logic                               aw_err;
  logic [WordAw-1:0]                  ar_word;
  logic [AddrWidth-LineLsb-1:0]       ar_line;
  logic                               ar_err;
  logic                               wr_accept;
  logic                               rd_accept;
  logic [LINE_LEN-1:0][DataWidth-1:0] stage_q;
  logic                               commit_q;
  logic [LineAw-1:0]                  commit_line_q;
  logic                               bvalid_q;
  logic [1:0]                         bresp_q;
  logic                               rd_p1_q;
  logic                               rd_p2_q;
  logic                               rvalid_q;
  logic [WordAw-1:0]                  rd_word_q;
  logic                               rd_err_q;
  logic [DataWidth-1:0]               rdata_q;
  logic [1:0]                         rresp_q;

  // Address decode and range check.
  assign aw_word = awaddr_i[LineLsb-1:ByteOffset];
  assign aw_line = awaddr_i[AddrWidth-1:LineLsb];
  assign aw_err  = (aw_word >= LINE_LEN) || (aw_line >= NUM_LINES);
  assign ar_word = araddr_i[LineLsb-1:ByteOffset];
  assign ar_line = araddr_i[AddrWidth-1:LineLsb];
  assign ar_err  = (ar_word >= LINE_LEN) || (ar_line >= NUM_LINES);

  // AW and W move together, and only with no commit or B beat outstanding.
  assign wr_accept = awvalid_i && wvalid_i && !commit_q && !bvalid_q;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else if (wr_accept && !aw_err) begin
      stage_q[aw_word] <= wdata_i;
    end
  end

  // The last word of a line raises the commit request until the grant.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q      <= 1'b0;
      commit_line_q <= '0;
    end else if (wr_accept && !aw_err && aw_word == WordAw'(LINE_LEN - 1)) begin
      commit_q      <= 1'b1;
      commit_line_q <= aw_line[LineAw-1:0];
    end else if (commit_gnt_i) begin
      commit_q <= 1'b0;
    end
  end

  assign commit_req_o  = commit_q;
  assign commit_line_o = commit_line_q;
  assign commit_data_o = stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RespOkay;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
      bresp_q  <= aw_err ? RespSlvErr : RespOkay;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  // One read in flight; the buffer line is sampled two edges after AR.
  assign rd_accept = arvalid_i && !rd_p1_q && !rd_p2_q && !rvalid_q;
  assign arready_o = rd_accept;
  assign rd_en_o   = rd_accept && !ar_err;
  assign rd_addr_o = ar_line[LineAw-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_p1_q  <= 1'b0;
      rd_p2_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rd_p1_q <= rd_accept;
      rd_p2_q <= rd_p1_q;
      if (rd_p2_q) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rd_word_q <= ar_word;
      rd_err_q  <= ar_err;
    end
    if (rd_p2_q) begin
      rdata_q <= rd_err_q ? '0 : rd_line_i[rd_word_q];
      rresp_q <= rd_err_q ? RespSlvErr : RespOkay;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

//--- write_arbiter.sv
// Round-robin choice of one line commit per cycle for the shared buffer.
// Grants are combinational, so an uncontended request is served in its own cycle.
module write_arbiter import tile_pkg::*; #(
  parameter int unsigned ROWS = 4,
  parameter int unsigned COLS = 4,
  localparam int unsigned RowAw = (ROWS > 1) ? $clog2(ROWS) : 1,
  localparam int unsigned ColAw = (COLS > 1) ? $clog2(COLS) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           row_req_i,
  input  logic                           col_req_i,
  output logic                           row_gnt_o,
  output logic                           col_gnt_o,
  input  logic [RowAw-1:0]               row_line_i,
  input  logic [ColAw-1:0]               col_line_i,
  input  logic [COLS-1:0][DataWidth-1:0] row_data_i,
  input  logic [ROWS-1:0][DataWidth-1:0] col_data_i,
  output logic                           row_write_en_o,
  output logic                           col_write_en_o,
  output logic [RowAw-1:0]               row_write_addr_o,
  output logic [ColAw-1:0]               col_write_addr_o,
  output logic [COLS-1:0][DataWidth-1:0] row_wdata_o,
  output logic [ROWS-1:0][DataWidth-1:0] col_wdata_o
);

  // High when the column port won the last grant.
  logic last_col_q;

  assign row_gnt_o = row_req_i && (!col_req_i || last_col_q);
  assign col_gnt_o = col_req_i && (!row_req_i || !last_col_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_col_q <= 1'b0;
    end else if (row_gnt_o || col_gnt_o) begin
      last_col_q <= col_gnt_o;
    end
  end

  // The loser's path stays disabled.
  assign row_write_en_o   = row_gnt_o;
  assign col_write_en_o   = col_gnt_o;
  assign row_write_addr_o = row_line_i;
  assign col_write_addr_o = col_line_i;
  assign row_wdata_o      = row_data_i;
  assign col_wdata_o      = col_data_i;

endmodule

//--- z_buffer_scm.sv
// Latch array of ROWS x COLS words with row and column write and read paths.
// Only one of the two write enables may be high in a cycle.
// A write is visible to a read enabled two edges later.
module z_buffer_scm import tile_pkg::*; #(
  parameter int unsigned ROWS = 4,
  parameter int unsigned COLS = 4,
  localparam int unsigned RowAw = (ROWS > 1) ? $clog2(ROWS) : 1,
  localparam int unsigned ColAw = (COLS > 1) ? $clog2(COLS) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           row_write_en_i,
  input  logic                           col_write_en_i,
  input  logic [RowAw-1:0]               row_write_addr_i,
  input  logic [ColAw-1:0]               col_write_addr_i,
  input  logic [COLS-1:0][DataWidth-1:0] row_wdata_i,
  input  logic [ROWS-1:0][DataWidth-1:0] col_wdata_i,
  input  logic                           row_read_en_i,
  input  logic                           col_read_en_i,
  input  logic [RowAw-1:0]               row_read_addr_i,
  input  logic [ColAw-1:0]               col_read_addr_i,
  output logic [COLS-1:0][DataWidth-1:0] row_rdata_o,
  output logic [ROWS-1:0][DataWidth-1:0] col_rdata_o
);

  logic [ROWS-1:0][COLS-1:0][DataWidth-1:0] buffer;
  logic [COLS-1:0][DataWidth-1:0]           row_wdata_q;
  logic [ROWS-1:0][DataWidth-1:0]           col_wdata_q;
  logic                                     row_sel_q;
  logic [RowAw-1:0]                         row_read_addr_q;
  logic [ColAw-1:0]                         col_read_addr_q;
  logic [ROWS-1:0][COLS-1:0]                clk_w;

  // Read addresses only move on their own enable.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_read_addr_q <= '0;
    end else if (row_read_en_i) begin
      row_read_addr_q <= row_read_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_read_addr_q <= '0;
    end else if (col_read_en_i) begin
      col_read_addr_q <= col_read_addr_i;
    end
  end

  for (genvar c = 0; c < COLS; c++) begin : gen_row_read
    assign row_rdata_o[c] = buffer[row_read_addr_q][c];
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_col_read
    assign col_rdata_o[r] = buffer[r][col_read_addr_q];
  end

  // Write data is held for the latch phase that follows the enable.
  always_ff @(posedge clk_i) begin
    if (row_write_en_i) begin
      row_wdata_q <= row_wdata_i;
    end
    if (col_write_en_i) begin
      col_wdata_q <= col_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_sel_q <= 1'b0;
    end else if (row_write_en_i || col_write_en_i) begin
      row_sel_q <= row_write_en_i;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    for (genvar c = 0; c < COLS; c++) begin : gen_cols
      logic                 word_en;
      logic [DataWidth-1:0] word_q;

      assign word_en = (row_write_en_i && row_write_addr_i == RowAw'(r)) ||
                       (col_write_en_i && col_write_addr_i == ColAw'(c));

      tc_clk_gating i_word_cg (
        .clk_i     (clk_i),
        .en_i      (word_en),
        .test_en_i (1'b0),
        .clk_o     (clk_w[r][c])
      );

      always_latch begin
        if (!rst_ni) begin
          word_q <= '0;
        end else if (clk_w[r][c]) begin
          word_q <= row_sel_q ? row_wdata_q[c] : col_wdata_q[r];
        end
      end

      assign buffer[r][c] = word_q;
    end
  end

endmodule

//--- tc_clk_gating.sv
// Behavioral clock gate for simulation and FPGA prototypes.
// Swap for the library cell in an ASIC flow.
module tc_clk_gating (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latched;

  // Enable is captured while the clock is low, so the gated clock cannot glitch.
  always_latch begin
    if (!clk_i) begin
      en_latched <= en_i | test_en_i;
    end
  end

  assign clk_o = clk_i & en_latched;

endmodule

//--- tile_pkg.sv
// Constants shared by every block of the tile transposer.
// The data width is fixed by the AXI4-Lite bus and also sets the buffer word size.
package tile_pkg;

  // AXI4-Lite bus widths.
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 12;

  // The decode ignores these byte offset bits below the word index.
  localparam int unsigned ByteOffset = 2;

  // Write and read response codes.
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

endpackage
